/* src/pet_pkg.sv */
`default_nettype none

package pet_pkg;

    // Bus widths
    localparam int ADDR_W = 17;
    localparam int DATA_W = 8;

    // Memory map
    localparam logic [15:0] RAM_TOP = 16'h7FFF;   // Top of low RAM
    localparam logic [15:0] IO_BASE = 16'hE800;   // I/O page E800-E8FF

    // Chip select bits within the I/O page
    localparam int PIA1_BIT = 4;
    localparam int PIA2_BIT = 5;
    localparam int VIA_BIT  = 6;
    localparam int CRTC_BIT = 7;

    // Graphics jumper readback, bit 0 of an SPI read
    localparam logic [ADDR_W-1:0] GFX_ADDR = 17'h0E80F;

    // Keyboard rows are written here over SPI, row index in the low nibble
    localparam logic [ADDR_W-1:0] KBD_BASE = 17'h1E800;
    localparam int KBD_ROWS = 10;

    // SPI frame layout
    localparam int FRAME_BYTES = 4;
    localparam int BYTE_CMD     = 0;    // rw_n and address bit 16
    localparam int BYTE_ADDR_HI = 1;
    localparam int BYTE_ADDR_LO = 2;
    localparam int BYTE_DATA    = 3;    // Write data, ignored on reads
    localparam int CMD_RW_BIT   = 7;
    localparam int CMD_A16_BIT  = 0;

endpackage

`default_nettype wire

/* src/spi_target.sv */
`default_nettype none

module spi_target (
    input  wire                         clk16_i,
    input  wire                         rst_n_i,
    input  wire                         spi_sck_i,
    input  wire                         spi_cs_ni,
    input  wire                         spi_rx_i,
    input  wire                         spi_done_i,
    input  wire [pet_pkg::DATA_W-1:0]   spi_rd_data_i,
    output logic                        spi_tx_o,
    output logic                        spi_ready_o,
    output logic                        spi_valid_o,
    output logic [pet_pkg::ADDR_W-1:0]  spi_addr_o,
    output logic [pet_pkg::DATA_W-1:0]  spi_wr_data_o,
    output logic                        spi_rw_no
);
    localparam int BYTE_CNT_W = $clog2(pet_pkg::FRAME_BYTES);

    // Two sync flops plus one more for edge detection
    logic [2:0] sck_q;
    logic [2:0] cs_q;
    logic [1:0] rx_q;

    logic [2:0]                  bit_cnt;
    logic [BYTE_CNT_W-1:0]       byte_cnt;
    logic [6:0]                  shift_in;
    logic                        rx_rw_n;
    logic [pet_pkg::ADDR_W-1:0]  rx_addr;
    logic                        done_q;
    logic [7:0]                  tx_hold;     // Byte 0 of the next frame
    logic [7:0]                  tx_shift;

    wire sck_rise  = sck_q[1] && !sck_q[2];
    wire sck_fall  = !sck_q[1] && sck_q[2];
    wire cs_active = !cs_q[1];
    wire cs_fall   = !cs_q[1] && cs_q[2];

    wire [7:0] rx_byte   = {shift_in, rx_q[1]};
    wire       byte_done = cs_active && sck_rise && (bit_cnt == 3'd7);
    wire       frame_done = byte_done && (byte_cnt == BYTE_CNT_W'(pet_pkg::BYTE_DATA));

    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            sck_q       <= '0;
            cs_q        <= '1;
            bit_cnt     <= '0;
            byte_cnt    <= '0;
            done_q      <= 1'b0;
            spi_valid_o <= 1'b0;
            spi_ready_o <= 1'b1;
            tx_hold     <= '0;
            tx_shift    <= '0;
        end else begin
            sck_q  <= {sck_q[1:0], spi_sck_i};
            cs_q   <= {cs_q[1:0], spi_cs_ni};
            done_q <= spi_done_i;

            if (!cs_active) begin
                bit_cnt  <= '0;
                byte_cnt <= '0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) byte_cnt <= byte_cnt + 1'b1;
            end

            // A frame arriving while busy is dropped
            if (frame_done && spi_ready_o) begin
                spi_valid_o <= 1'b1;
                spi_ready_o <= 1'b0;
            end else if (spi_done_i) begin
                spi_valid_o <= 1'b0;
                spi_ready_o <= 1'b1;
            end

            // Read data is registered by bus control on the done edge
            if (done_q) tx_hold <= spi_rd_data_i;

            if (cs_fall) begin
                tx_shift <= tx_hold;
            end else if (cs_active && sck_fall) begin
                tx_shift <= {tx_shift[6:0], 1'b0};   // Mode 0, change on falling
            end
        end
    end

    always_ff @(posedge clk16_i) begin
        rx_q <= {rx_q[0], spi_rx_i};
        if (cs_active && sck_rise) shift_in <= {shift_in[5:0], rx_q[1]};

        if (byte_done) begin
            case (byte_cnt)
                BYTE_CNT_W'(pet_pkg::BYTE_CMD): begin
                    rx_rw_n                     <= rx_byte[pet_pkg::CMD_RW_BIT];
                    rx_addr[pet_pkg::ADDR_W-1]  <= rx_byte[pet_pkg::CMD_A16_BIT];
                end
                BYTE_CNT_W'(pet_pkg::BYTE_ADDR_HI): rx_addr[15:8] <= rx_byte;
                BYTE_CNT_W'(pet_pkg::BYTE_ADDR_LO): rx_addr[7:0]  <= rx_byte;
                default: ;
            endcase
        end

        if (frame_done && spi_ready_o) begin
            spi_addr_o    <= rx_addr;
            spi_rw_no     <= rx_rw_n;
            spi_wr_data_o <= rx_byte;
        end
    end

    assign spi_tx_o = tx_shift[7];

endmodule

`default_nettype wire

/* src/bus_timing.sv */
`default_nettype none

module bus_timing #(
    parameter int CYCLE_LEN = 16    // Even, at least 8
) (
    input  wire  clk16_i,
    input  wire  rst_n_i,
    input  wire  spi_valid_i,
    output logic spi_done_o,
    output logic spi_en_o,
    output logic cpu_en_o,
    output logic strobe_o,
    output logic cpu_clk_o,
    output logic cpu_be_o
);
    localparam int CNT_W = $clog2(CYCLE_LEN);
    localparam logic [CNT_W-1:0] SPI_LAST = CNT_W'(CYCLE_LEN / 2 - 1);
    localparam logic [CNT_W-1:0] CPU_LAST = CNT_W'(CYCLE_LEN - 1);

    logic [CNT_W-1:0] count;
    logic             claim_q;    // SPI slot claimed at count 0

    wire cpu_half = count > SPI_LAST;

    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            count   <= '0;
            claim_q <= 1'b0;
        end else begin
            count <= (count == CPU_LAST) ? '0 : count + 1'b1;
            if (count == '0) claim_q <= spi_valid_i;
        end
    end

    // A transaction that shows up mid-slot waits for the next cycle
    assign spi_en_o = !cpu_half && ((count == '0) ? spi_valid_i : claim_q);
    assign cpu_be_o = !spi_en_o;

    assign cpu_en_o  = cpu_half;
    assign cpu_clk_o = cpu_half;   // Phi2 high in the CPU half

    assign strobe_o   = (count == SPI_LAST) || (count == CPU_LAST);
    assign spi_done_o = spi_en_o && (count == SPI_LAST);

endmodule

`default_nettype wire

/* src/address_decoding.sv */
`default_nettype none

module address_decoding (
    input  wire [pet_pkg::ADDR_W-1:0] addr_i,
    output logic                      ram_en_o,
    output logic                      pia1_en_o,
    output logic                      pia2_en_o,
    output logic                      via_en_o,
    output logic                      crtc_en_o,
    output logic                      io_en_o
);
    wire bank1   = addr_i[pet_pkg::ADDR_W-1];     // Second 64K, all RAM
    wire io_page = !bank1 && (addr_i[15:8] == pet_pkg::IO_BASE[15:8]);
    wire low_ram = !bank1 && (addr_i[15:0] <= pet_pkg::RAM_TOP);

    // Video RAM and ROM images also sit in RAM
    wire rom_area = !bank1 && !low_ram && !io_page;

    assign ram_en_o = bank1 || low_ram || rom_area;
    assign io_en_o  = io_page;

    // One address bit per chip inside the I/O page
    assign pia1_en_o = io_page && addr_i[pet_pkg::PIA1_BIT];
    assign pia2_en_o = io_page && addr_i[pet_pkg::PIA2_BIT];
    assign via_en_o  = io_page && addr_i[pet_pkg::VIA_BIT];
    assign crtc_en_o = io_page && addr_i[pet_pkg::CRTC_BIT];

endmodule

`default_nettype wire

/* src/keyboard.sv */
`default_nettype none

module keyboard (
    input  wire                         clk16_i,
    input  wire                         rst_n_i,
    input  wire                         strobe_i,
    input  wire                         spi_wr_en_i,
    input  wire [pet_pkg::ADDR_W-1:0]   spi_addr_i,
    input  wire [pet_pkg::DATA_W-1:0]   spi_data_i,
    input  wire                         cpu_rd_en_i,
    input  wire                         cpu_wr_en_i,
    input  wire                         pia1_en_i,
    input  wire [1:0]                   pia1_rs_i,
    input  wire [pet_pkg::DATA_W-1:0]   bus_data_i,
    output logic [pet_pkg::DATA_W-1:0]  kbd_data_o,
    output logic                        kbd_oe_o
);
    logic [pet_pkg::DATA_W-1:0] rows [pet_pkg::KBD_ROWS];   // Active low keys
    logic [3:0]                 row_sel;

    wire [3:0] spi_row    = spi_addr_i[3:0];
    wire       kbd_window = spi_addr_i[pet_pkg::ADDR_W-1:4] == pet_pkg::KBD_BASE[pet_pkg::ADDR_W-1:4];
    wire       row_wr     = strobe_i && spi_wr_en_i && kbd_window
                            && (spi_row < 4'(pet_pkg::KBD_ROWS));

    // PIA1 port A data register, low nibble drives the row decoder
    wire sel_wr = strobe_i && cpu_wr_en_i && pia1_en_i && (pia1_rs_i == 2'd0);

    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < pet_pkg::KBD_ROWS; i++) begin
                rows[i] <= '1;      // No key pressed
            end
            row_sel <= '0;
        end else begin
            if (row_wr) rows[spi_row] <= spi_data_i;
            if (sel_wr) row_sel <= bus_data_i[3:0];
        end
    end

    // Port B read is answered here instead of by the PIA
    assign kbd_oe_o = cpu_rd_en_i && pia1_en_i && (pia1_rs_i == 2'd2);

    assign kbd_data_o = (row_sel < 4'(pet_pkg::KBD_ROWS)) ? rows[row_sel] : 8'hFF;

endmodule

`default_nettype wire

/* src/bus_control.sv */
`default_nettype none

module bus_control (
    input  wire                         clk16_i,
    input  wire                         rst_n_i,
    input  wire                         strobe_i,
    input  wire                         spi_en_i,
    input  wire                         cpu_en_i,
    input  wire                         spi_rw_ni,
    input  wire [pet_pkg::ADDR_W-1:0]   spi_addr_i,
    input  wire [pet_pkg::DATA_W-1:0]   spi_wr_data_i,
    input  wire [15:0]                  bus_addr_i,
    input  wire [pet_pkg::DATA_W-1:0]   bus_data_i,
    input  wire                         bus_rw_ni,
    input  wire [pet_pkg::DATA_W-1:0]   kbd_data_i,
    input  wire                         kbd_oe_i,
    input  wire                         gfx_i,
    input  wire                         ram_en_i,
    input  wire                         pia1_en_i,
    input  wire                         pia2_en_i,
    input  wire                         via_en_i,
    input  wire                         io_en_i,
    output logic [pet_pkg::ADDR_W-1:0]  dec_addr_o,
    output logic [pet_pkg::DATA_W-1:0]  spi_rd_data_o,
    output logic                        cpu_rd_en_o,
    output logic                        cpu_wr_en_o,
    output logic                        spi_wr_en_o,
    output logic [pet_pkg::ADDR_W-1:0]  bus_addr_o,
    output logic                        bus_addr_oe_o,
    output logic [pet_pkg::DATA_W-1:0]  bus_data_o,
    output logic                        bus_data_oe_o,
    output logic                        bus_rw_no,
    output logic                        bus_rw_noe_o,
    output logic                        ram_oe_o,
    output logic                        ram_we_o,
    output logic [11:10]                ram_addr_o,
    output logic                        pia1_cs_o,
    output logic                        pia2_cs_o,
    output logic                        via_cs_o,
    output logic                        io_oe_o
);
    wire spi_rd_en = spi_en_i && spi_rw_ni;

    assign spi_wr_en_o = spi_en_i && !spi_rw_ni;
    assign cpu_rd_en_o = cpu_en_i && bus_rw_ni;
    assign cpu_wr_en_o = cpu_en_i && !bus_rw_ni;

    // CPU only reaches the first bank
    assign dec_addr_o = spi_en_i ? spi_addr_i : {1'b0, bus_addr_i};

    assign bus_addr_o    = dec_addr_o;
    assign bus_addr_oe_o = spi_en_i;
    assign bus_rw_no     = spi_rw_ni;
    assign bus_rw_noe_o  = spi_en_i;

    assign bus_data_oe_o = spi_wr_en_o || kbd_oe_i;
    assign bus_data_o    = kbd_oe_i ? kbd_data_i : spi_wr_data_i;

    assign ram_oe_o   = ram_en_i && (spi_rd_en || cpu_rd_en_o);
    assign ram_we_o   = ram_en_i && (spi_wr_en_o || cpu_wr_en_o) && strobe_i;
    assign ram_addr_o = dec_addr_o[11:10];       // No VRAM mirroring here

    // PIA1 stays quiet while the keyboard drives the bus
    assign pia1_cs_o = !kbd_oe_i && pia1_en_i && cpu_en_i;
    assign pia2_cs_o = pia2_en_i && cpu_en_i;
    assign via_cs_o  = via_en_i && cpu_en_i;
    assign io_oe_o   = !kbd_oe_i && io_en_i && cpu_en_i;

    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            spi_rd_data_o <= '0;
        end else if (strobe_i && spi_rd_en) begin
            if (spi_addr_i == pet_pkg::GFX_ADDR) begin
                spi_rd_data_o <= {7'h00, gfx_i};   // Jumper readback
            end else begin
                spi_rd_data_o <= bus_data_i;
            end
        end
    end

endmodule

`default_nettype wire

/* src/pet_main.sv */
`default_nettype none

module pet_main #(
    parameter int CYCLE_LEN = 16
) (
    input  wire                         clk16_i,
    input  wire                         rst_n_i,
    input  wire                         spi1_sck_i,
    input  wire                         spi1_cs_ni,
    input  wire                         spi1_rx_i,
    output logic                        spi1_tx_o,
    output logic                        spi_ready_o,
    input  wire [15:0]                  bus_addr_i,
    output logic [pet_pkg::ADDR_W-1:0]  bus_addr_o,
    output logic                        bus_addr_oe_o,
    input  wire [pet_pkg::DATA_W-1:0]   bus_data_i,
    output logic [pet_pkg::DATA_W-1:0]  bus_data_o,
    output logic                        bus_data_oe_o,
    input  wire                         bus_rw_ni,
    output logic                        bus_rw_no,
    output logic                        bus_rw_noe_o,
    output logic                        cpu_clk_o,
    output logic                        cpu_be_o,
    output logic                        ram_oe_o,
    output logic                        ram_we_o,
    output logic [11:10]                ram_addr_o,
    output logic                        pia1_cs_o,
    output logic                        pia2_cs_o,
    output logic                        via_cs_o,
    output logic                        io_oe_o,
    input  wire                         gfx_i
);
    // Pending SPI transaction
    logic                       spi_valid;
    logic                       spi_done;
    logic                       spi_rw_n;
    logic [pet_pkg::ADDR_W-1:0] spi_addr;
    logic [pet_pkg::DATA_W-1:0] spi_wr_data;
    logic [pet_pkg::DATA_W-1:0] spi_rd_data;

    // Slot timing
    logic spi_en;
    logic cpu_en;
    logic strobe;

    logic                       cpu_rd_en;
    logic                       cpu_wr_en;
    logic                       spi_wr_en;
    logic [pet_pkg::ADDR_W-1:0] dec_addr;

    logic ram_en;
    logic pia1_en;
    logic pia2_en;
    logic via_en;
    logic io_en;

    logic [pet_pkg::DATA_W-1:0] kbd_data;
    logic                       kbd_oe;

    spi_target spi_target_inst (
        .clk16_i       (clk16_i),
        .rst_n_i       (rst_n_i),
        .spi_sck_i     (spi1_sck_i),
        .spi_cs_ni     (spi1_cs_ni),
        .spi_rx_i      (spi1_rx_i),
        .spi_done_i    (spi_done),
        .spi_rd_data_i (spi_rd_data),
        .spi_tx_o      (spi1_tx_o),
        .spi_ready_o   (spi_ready_o),
        .spi_valid_o   (spi_valid),
        .spi_addr_o    (spi_addr),
        .spi_wr_data_o (spi_wr_data),
        .spi_rw_no     (spi_rw_n)
    );

    bus_timing #(
        .CYCLE_LEN (CYCLE_LEN)
    ) bus_timing_inst (
        .clk16_i     (clk16_i),
        .rst_n_i     (rst_n_i),
        .spi_valid_i (spi_valid),
        .spi_done_o  (spi_done),
        .spi_en_o    (spi_en),
        .cpu_en_o    (cpu_en),
        .strobe_o    (strobe),
        .cpu_clk_o   (cpu_clk_o),
        .cpu_be_o    (cpu_be_o)
    );

    address_decoding address_decoding_inst (
        .addr_i    (dec_addr),
        .ram_en_o  (ram_en),
        .pia1_en_o (pia1_en),
        .pia2_en_o (pia2_en),
        .via_en_o  (via_en),
        .crtc_en_o (),          // CRTC is not part of this core
        .io_en_o   (io_en)
    );

    keyboard keyboard_inst (
        .clk16_i     (clk16_i),
        .rst_n_i     (rst_n_i),
        .strobe_i    (strobe),
        .spi_wr_en_i (spi_wr_en),
        .spi_addr_i  (spi_addr),
        .spi_data_i  (spi_wr_data),
        .cpu_rd_en_i (cpu_rd_en),
        .cpu_wr_en_i (cpu_wr_en),
        .pia1_en_i   (pia1_en),
        .pia1_rs_i   (bus_addr_i[1:0]),
        .bus_data_i  (bus_data_i),
        .kbd_data_o  (kbd_data),
        .kbd_oe_o    (kbd_oe)
    );

    bus_control bus_control_inst (
        .clk16_i       (clk16_i),
        .rst_n_i       (rst_n_i),
        .strobe_i      (strobe),
        .spi_en_i      (spi_en),
        .cpu_en_i      (cpu_en),
        .spi_rw_ni     (spi_rw_n),
        .spi_addr_i    (spi_addr),
        .spi_wr_data_i (spi_wr_data),
        .bus_addr_i    (bus_addr_i),
        .bus_data_i    (bus_data_i),
        .bus_rw_ni     (bus_rw_ni),
        .kbd_data_i    (kbd_data),
        .kbd_oe_i      (kbd_oe),
        .gfx_i         (gfx_i),
        .ram_en_i      (ram_en),
        .pia1_en_i     (pia1_en),
        .pia2_en_i     (pia2_en),
        .via_en_i      (via_en),
        .io_en_i       (io_en),
        .dec_addr_o    (dec_addr),
        .spi_rd_data_o (spi_rd_data),
        .cpu_rd_en_o   (cpu_rd_en),
        .cpu_wr_en_o   (cpu_wr_en),
        .spi_wr_en_o   (spi_wr_en),
        .bus_addr_o    (bus_addr_o),
        .bus_addr_oe_o (bus_addr_oe_o),
        .bus_data_o    (bus_data_o),
        .bus_data_oe_o (bus_data_oe_o),
        .bus_rw_no     (bus_rw_no),
        .bus_rw_noe_o  (bus_rw_noe_o),
        .ram_oe_o      (ram_oe_o),
        .ram_we_o      (ram_we_o),
        .ram_addr_o    (ram_addr_o),
        .pia1_cs_o     (pia1_cs_o),
        .pia2_cs_o     (pia2_cs_o),
        .via_cs_o      (via_cs_o),
        .io_oe_o       (io_oe_o)
    );

endmodule

`default_nettype wire

/* sim/pet_main_asserts.sv */
`default_nettype none

module pet_main_asserts (
    input wire clk16_i,
    input wire rst_n_i,
    input wire spi_ready_o,
    input wire cpu_clk_o,
    input wire cpu_be_o,
    input wire ram_we_o,
    input wire bus_data_oe_o,
    input wire bus_addr_oe_o,
    input wire bus_rw_noe_o,
    input wire pia1_cs_o,
    input wire pia2_cs_o,
    input wire via_cs_o,
    input wire io_oe_o
);
    int fail_count = 0;   // Read by the testbench at the end

    // Writes happen in an SPI slot or in the CPU half
    write_in_slot: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        (ram_we_o || bus_data_oe_o) |-> (!cpu_be_o || cpu_clk_o))
    else begin
        fail_count++;
        $error("bus write outside of an SPI or CPU slot");
    end

    one_chip_select: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        $onehot0({pia1_cs_o, pia2_cs_o, via_cs_o}))
    else begin
        fail_count++;
        $error("more than one chip select active");
    end

    // An SPI slot only runs for a pending frame
    slot_needs_frame: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        $fell(cpu_be_o) |-> !spi_ready_o)
    else begin
        fail_count++;
        $error("SPI slot claimed while no frame was pending");
    end

    // Ready comes back right after the SPI slot ends
    ready_after_slot: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        $rose(spi_ready_o) |-> $past(!cpu_be_o) && cpu_be_o && cpu_clk_o)
    else begin
        fail_count++;
        $error("spi_ready_o rose outside the end of an SPI slot");
    end

    reset_values: assert property (@(posedge clk16_i)
        !rst_n_i |=> spi_ready_o && cpu_be_o && !ram_we_o && !bus_data_oe_o
                     && !bus_addr_oe_o && !bus_rw_noe_o && !pia1_cs_o
                     && !pia2_cs_o && !via_cs_o && !io_oe_o)
    else begin
        fail_count++;
        $error("control outputs not inactive after reset");
    end

endmodule

bind pet_main pet_main_asserts asserts_inst (
    .clk16_i       (clk16_i),
    .rst_n_i       (rst_n_i),
    .spi_ready_o   (spi_ready_o),
    .cpu_clk_o     (cpu_clk_o),
    .cpu_be_o      (cpu_be_o),
    .ram_we_o      (ram_we_o),
    .bus_data_oe_o (bus_data_oe_o),
    .bus_addr_oe_o (bus_addr_oe_o),
    .bus_rw_noe_o  (bus_rw_noe_o),
    .pia1_cs_o     (pia1_cs_o),
    .pia2_cs_o     (pia2_cs_o),
    .via_cs_o      (via_cs_o),
    .io_oe_o       (io_oe_o)
);

`default_nettype wire

/* sim/tb_pet_main.sv */
`default_nettype none

module tb_pet_main #(
    parameter int CYCLE_LEN = 16
);
    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        sck = 1'b0;
    logic        cs_n = 1'b1;
    logic        rx = 1'b0;
    logic [15:0] bus_addr_i = 16'h0400;
    logic [7:0]  bus_data_i = 8'h00;
    logic        bus_rw_ni = 1'b1;
    logic        gfx = 1'b0;

    wire        spi1_tx_o, spi_ready_o, bus_addr_oe_o, bus_data_oe_o;
    wire        bus_rw_no, bus_rw_noe_o, cpu_clk_o, cpu_be_o, ram_oe_o, ram_we_o;
    wire        pia1_cs_o, pia2_cs_o, via_cs_o, io_oe_o;
    wire [16:0] bus_addr_o;
    wire [7:0]  bus_data_o;
    wire [11:10] ram_addr_o;

    logic [7:0]  mem [0:131071];   // External RAM, both banks
    logic [7:0]  cpu_wdata = 8'h00;
    logic [31:0] lfsr = 32'hd4f7;
    logic [16:0] ram_a;
    logic [16:0] we_addr;
    logic [7:0]  we_data;
    logic [11:10] we_ram_addr;
    logic        we_rw = 1'b1;
    logic        rd_rw = 1'b0;
    int          spi_we_count = 0;
    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;

    pet_main #(.CYCLE_LEN(CYCLE_LEN)) pet_main_inst (
        .clk16_i(clk), .rst_n_i(rst_n), .spi1_sck_i(sck), .spi1_cs_ni(cs_n),
        .spi1_rx_i(rx), .spi1_tx_o(spi1_tx_o), .spi_ready_o(spi_ready_o),
        .bus_addr_i(bus_addr_i), .bus_addr_o(bus_addr_o), .bus_addr_oe_o(bus_addr_oe_o),
        .bus_data_i(bus_data_i), .bus_data_o(bus_data_o), .bus_data_oe_o(bus_data_oe_o),
        .bus_rw_ni(bus_rw_ni), .bus_rw_no(bus_rw_no), .bus_rw_noe_o(bus_rw_noe_o),
        .cpu_clk_o(cpu_clk_o), .cpu_be_o(cpu_be_o), .ram_oe_o(ram_oe_o),
        .ram_we_o(ram_we_o), .ram_addr_o(ram_addr_o), .pia1_cs_o(pia1_cs_o),
        .pia2_cs_o(pia2_cs_o), .via_cs_o(via_cs_o), .io_oe_o(io_oe_o), .gfx_i(gfx)
    );

    always #5 clk = !clk;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // RAM model, also records SPI-slot writes
    always @(negedge clk) begin
        ram_a = bus_addr_oe_o ? bus_addr_o : {1'b0, bus_addr_i};
        if (ram_we_o) begin
            mem[ram_a] <= bus_data_oe_o ? bus_data_o : bus_data_i;
            if (!cpu_be_o) begin
                spi_we_count++;
                we_addr = bus_addr_o;
                we_data = bus_data_o;
                we_ram_addr = ram_addr_o;
                we_rw = bus_rw_no;
            end
        end
        if (ram_oe_o && !cpu_be_o) rd_rw = bus_rw_no;   // SPI read slot
        bus_data_i <= ram_oe_o ? mem[ram_a] : cpu_wdata;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("Timed out waiting for %s", what);
    endtask

    task automatic wait_cpu_clk(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (cpu_clk_o !== level && n < 2 * CYCLE_LEN) begin
            @(negedge clk);
            n++;
        end
        if (cpu_clk_o !== level) note_timeout("the CPU clock level");
    endtask

    // A transaction completes within two CPU cycles
    task automatic wait_ready();
        int n;
        n = 0;
        while (spi_ready_o !== 1'b1 && n < 2 * CYCLE_LEN) begin
            @(negedge clk);
            n++;
        end
        if (spi_ready_o !== 1'b1) note_timeout("spi_ready_o");
    endtask

    // Mode 0 master, four clocks per SCK half period
    task automatic send_frame(input logic [31:0] frame, output logic [7:0] miso);
        miso = '0;
        @(negedge clk);
        cs_n = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            rx = frame[i];
            repeat (4) @(negedge clk);
            if (i >= 24) miso = {miso[6:0], spi1_tx_o};
            sck = 1'b1;
            repeat (4) @(negedge clk);
            sck = 1'b0;
        end
        repeat (4) @(negedge clk);
        cs_n = 1'b1;
        wait_ready();
    endtask

    function automatic logic [31:0] make_frame(input logic rw_n, input logic [16:0] a,
                                               input logic [7:0] d);
        return {rw_n, 6'b0, a[16], a[15:0], d};
    endfunction

    // Drives one CPU access, returns inside the CPU half
    task automatic cpu_begin(input logic [15:0] a, input logic rw_n, input logic [7:0] d);
        wait_cpu_clk(1'b0);
        bus_addr_i = a;
        bus_rw_ni  = rw_n;
        cpu_wdata  = d;
        wait_cpu_clk(1'b1);
    endtask

    task automatic cpu_end();
        wait_cpu_clk(1'b0);
        bus_addr_i = 16'h0400;   // Idle read of low RAM
        bus_rw_ni  = 1'b1;
    endtask

    task automatic check_decode(input logic [15:0] a);
        logic io;
        logic kbd;
        io  = a[15:8] == 8'hE8;
        kbd = io && a[4] && (a[1:0] == 2'd2);
        cpu_begin(a, 1'b1, 8'h00);
        check_value("ram_oe_o", ram_oe_o, !io);
        check_value("ram_addr_o", ram_addr_o, a[11:10]);
        check_value("pia1_cs_o", pia1_cs_o, io && a[4] && !kbd);
        check_value("pia2_cs_o", pia2_cs_o, io && a[5]);
        check_value("via_cs_o", via_cs_o, io && a[6]);
        check_value("io_oe_o", io_oe_o, io && !kbd);
        cpu_end();
    endtask

    initial begin
        logic [16:0] addr;
        logic [7:0]  data;
        logic [7:0]  miso;
        logic [7:0]  exp;
        logic [3:0]  row;
        logic [15:0] dec_list [12];

        for (int a = 0; a < 131072; a++) begin
            mem[a] = a[7:0] ^ a[15:8] ^ {7'b0, a[16]} ^ 8'h5A;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Idle outputs after reset
        check_value("spi_ready_o", spi_ready_o, 1);
        check_value("cpu_be_o", cpu_be_o, 1);
        check_value("ram_we_o", ram_we_o, 0);
        check_value("bus_addr_oe_o", bus_addr_oe_o, 0);
        check_value("bus_data_oe_o", bus_data_oe_o, 0);
        check_value("bus_rw_noe_o", bus_rw_noe_o, 0);
        check_value("pia1_cs_o", pia1_cs_o, 0);
        check_value("pia2_cs_o", pia2_cs_o, 0);
        check_value("via_cs_o", via_cs_o, 0);
        check_value("io_oe_o", io_oe_o, 0);

        // SPI writes and read-backs, never in the I/O page
        for (int k = 0; k < 4; k++) begin
            addr[16] = 1'(rand_bits(1));
            addr[15] = 1'b0;
            addr[14:0] = 15'(rand_bits(15));
            data = 8'(rand_bits(8));
            spi_we_count = 0;
            send_frame(make_frame(1'b0, addr, data), miso);
            check_value("ram_we_o pulses", spi_we_count, 1);
            check_value("bus_addr_o", we_addr, addr);
            check_value("bus_data_o", we_data, data);
            check_value("ram_addr_o", we_ram_addr, addr[11:10]);
            check_value("bus_rw_no", we_rw, 0);
            exp = data;
            rd_rw = 1'b0;
            send_frame(make_frame(1'b1, addr, 8'h00), miso);
            check_value("bus_rw_no", rd_rw, 1);
            gfx = k[0];
            send_frame(make_frame(1'b1, 17'h0E80F, 8'h00), miso);
            check_value("spi1_tx_o", miso, exp);
            send_frame(make_frame(1'b1, {1'b0, addr[15:0]}, 8'h00), miso);
            check_value("spi1_tx_o", miso, {7'b0, k[0]});
        end

        dec_list = '{16'h0000, 16'h7FFF, 16'h8000, 16'hC000, 16'hE800, 16'hE810,
                     16'hE812, 16'hE820, 16'hE840, 16'hE880, 16'hF000, 16'hFFFF};
        foreach (dec_list[i]) check_decode(dec_list[i]);
        for (int k = 0; k < 6; k++) check_decode({1'b0, 15'(rand_bits(15))});

        // Keyboard rows through PIA1
        for (int k = 0; k < 3; k++) begin
            row  = 4'(rand_bits(4) % 10);
            data = 8'(rand_bits(8));
            send_frame(make_frame(1'b0, 17'h1E800 | {13'b0, row}, data), miso);
            cpu_begin(16'hE810, 1'b0, {4'h0, row});
            cpu_end();
            cpu_begin(16'hE812, 1'b1, 8'h00);
            check_value("bus_data_o", bus_data_o, data);
            check_value("bus_data_oe_o", bus_data_oe_o, 1);
            check_value("pia1_cs_o", pia1_cs_o, 0);
            cpu_end();
        end
        cpu_begin(16'hE810, 1'b0, 8'h0A);
        cpu_end();
        cpu_begin(16'hE812, 1'b1, 8'h00);
        check_value("bus_data_o", bus_data_o, 8'hFF);
        cpu_end();

        errors += pet_main_inst.asserts_inst.fail_count;
        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* pet_clone.f */
src/pet_pkg.sv
src/spi_target.sv
src/bus_timing.sv
src/address_decoding.sv
src/keyboard.sv
src/bus_control.sv
src/pet_main.sv
sim/pet_main_asserts.sv
sim/tb_pet_main.sv

/* Makefile */
TOP := tb_pet_main

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with CYCLE_LEN 16 and 8"
	@echo "  clean  remove the build directories"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f pet_clone.f \
		--top-module $(TOP) -GCYCLE_LEN=16 -Mdir obj_16
	./obj_16/V$(TOP) | tee /dev/stderr | grep -q "Everything OK"
	verilator --binary --timing --assert -Wno-fatal -f pet_clone.f \
		--top-module $(TOP) -GCYCLE_LEN=8 -Mdir obj_8
	./obj_8/V$(TOP) | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_16 obj_8
